/* Makefile */
TOP = tb_exec

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

/* hw/exec_pkg.sv */
package exec_pkg;

    // rename tag widths shared by the whole stage
    localparam int ROB_ADDR_WIDTH = 5;
    localparam int ARCH_REG_BITS  = 5;

    // multiplier latency in registered stages
    localparam int MUL_STAGES = 4;

    typedef logic [31:0]               word_t;
    typedef logic [ROB_ADDR_WIDTH-1:0] rob_idx_t;
    typedef logic [ARCH_REG_BITS-1:0]  arch_reg_t;

    // integer ALU operations, register and immediate forms
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_t;

    // RV32M multiply variants
    typedef enum logic [1:0] {
        MUL,
        MULH,
        MULHSU,
        MULHU
    } mul_op_t;

    // conditional branches and the two jumps
    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR
    } br_op_t;

endpackage : exec_pkg

/* hw/exec_top.sv */
`timescale 1ns/1ps

module exec_top
    import exec_pkg::*;
#(
    parameter int PHYS_REG_BITS = 6
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_alu, start_mul, start_br,
    input  word_t                    rs1_v, rs2_v, imm, pc,
    input  logic                     use_imm,
    input  alu_op_t                  alu_op,
    input  mul_op_t                  mul_op,
    input  br_op_t                   br_op,
    input  rob_idx_t                 rob_idx,
    input  logic [PHYS_REG_BITS-1:0] pd,
    input  arch_reg_t                rd,
    input  logic                     flush,
    output logic                     cdb_valid,
    output rob_idx_t                 cdb_rob_idx,
    output logic [PHYS_REG_BITS-1:0] cdb_pd,
    output arch_reg_t                cdb_rd,
    output word_t                    cdb_rd_v,
    output logic                     cdb_pc_select,
    output word_t                    cdb_pc_branch,
    output logic                     busy_alu,
    output logic                     busy_br
);

    // latched work, one set per unit
    logic                     alu_valid, mul_valid, br_valid;
    word_t                    alu_rs1_v, alu_rs2_v, alu_imm;
    logic                     alu_use_imm;
    alu_op_t                  alu_op_q;
    word_t                    mul_rs1_v, mul_rs2_v;
    mul_op_t                  mul_op_q;
    word_t                    br_rs1_v, br_rs2_v, br_imm, br_pc;
    br_op_t                   br_op_q;
    rob_idx_t                 alu_rob_idx, mul_rob_idx, br_rob_idx;
    logic [PHYS_REG_BITS-1:0] alu_pd, mul_pd, br_pd;
    arch_reg_t                alu_rd, mul_rd, br_rd;

    issue_stage #(
        .PHYS_REG_BITS (PHYS_REG_BITS)
    ) u_issue (.*);

    execute #(
        .PHYS_REG_BITS (PHYS_REG_BITS)
    ) u_execute (.*);

endmodule : exec_top

/* hw/execute.sv */
`timescale 1ns/1ps

module execute
    import exec_pkg::*;
#(
    parameter int PHYS_REG_BITS = 6
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     alu_valid, mul_valid, br_valid,
    input  word_t                    alu_rs1_v, alu_rs2_v, alu_imm,
    input  logic                     alu_use_imm,
    input  alu_op_t                  alu_op_q,
    input  word_t                    mul_rs1_v, mul_rs2_v,
    input  mul_op_t                  mul_op_q,
    input  word_t                    br_rs1_v, br_rs2_v, br_imm, br_pc,
    input  br_op_t                   br_op_q,
    input  rob_idx_t                 alu_rob_idx, mul_rob_idx, br_rob_idx,
    input  logic [PHYS_REG_BITS-1:0] alu_pd, mul_pd, br_pd,
    input  arch_reg_t                alu_rd, mul_rd, br_rd,
    output logic                     cdb_valid,
    output rob_idx_t                 cdb_rob_idx,
    output logic [PHYS_REG_BITS-1:0] cdb_pd,
    output arch_reg_t                cdb_rd,
    output word_t                    cdb_rd_v,
    output logic                     cdb_pc_select,
    output word_t                    cdb_pc_branch,
    output logic                     busy_alu,
    output logic                     busy_br
);

    word_t                    alu_rd_v;
    word_t                    br_rd_v;
    logic                     br_pc_select;
    word_t                    br_pc_branch;
    logic                     mul_res_valid;
    word_t                    mul_res_rd_v;
    rob_idx_t                 mul_res_rob_idx;
    logic [PHYS_REG_BITS-1:0] mul_res_pd;
    arch_reg_t                mul_res_rd;
    logic [MUL_STAGES-2:0]    mul_track;

    fu_alu u_alu (
        .rs1_v   (alu_rs1_v),
        .rs2_v   (alu_rs2_v),
        .imm     (alu_imm),
        .use_imm (alu_use_imm),
        .op      (alu_op_q),
        .rd_v    (alu_rd_v)
    );

    fu_mult #(
        .PHYS_REG_BITS (PHYS_REG_BITS)
    ) u_mult (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in_valid    (mul_valid),
        .rs1_v       (mul_rs1_v),
        .rs2_v       (mul_rs2_v),
        .op          (mul_op_q),
        .rob_idx     (mul_rob_idx),
        .pd          (mul_pd),
        .rd          (mul_rd),
        .out_valid   (mul_res_valid),
        .out_rd_v    (mul_res_rd_v),
        .out_rob_idx (mul_res_rob_idx),
        .out_pd      (mul_res_pd),
        .out_rd      (mul_res_rd)
    );

    fu_branch u_branch (
        .rs1_v     (br_rs1_v),
        .rs2_v     (br_rs2_v),
        .imm       (br_imm),
        .pc        (br_pc),
        .op        (br_op_q),
        .rd_v      (br_rd_v),
        .pc_select (br_pc_select),
        .pc_branch (br_pc_branch)
    );

    // shadow of the mul valids up to the stage before the result
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_track <= '0;
        end else begin
            mul_track <= {mul_track[MUL_STAGES-3:0], mul_valid};
        end
    end

    // a start now would land on the CDB together with the mul result
    assign busy_alu = mul_track[MUL_STAGES-2];
    assign busy_br  = busy_alu;

    // CDB merge: mul first, then branch, then ALU
    always_comb begin
        cdb_valid     = alu_valid;
        cdb_rob_idx   = alu_rob_idx;
        cdb_pd        = alu_pd;
        cdb_rd        = alu_rd;
        cdb_rd_v      = alu_rd_v;
        cdb_pc_select = 1'b0;
        cdb_pc_branch = '0;
        if (mul_res_valid) begin
            cdb_valid   = 1'b1;
            cdb_rob_idx = mul_res_rob_idx;
            cdb_pd      = mul_res_pd;
            cdb_rd      = mul_res_rd;
            cdb_rd_v    = mul_res_rd_v;
        end else if (br_valid) begin
            cdb_valid     = 1'b1;
            cdb_rob_idx   = br_rob_idx;
            cdb_pd        = br_pd;
            cdb_rd        = br_rd;
            cdb_rd_v      = br_rd_v;
            cdb_pc_select = br_pc_select;
            cdb_pc_branch = br_pc_branch;
        end
        // nothing reaches the ROB in a flush cycle
        if (flush) begin
            cdb_valid     = 1'b0;
            cdb_rob_idx   = '0;
            cdb_pd        = '0;
            cdb_rd        = '0;
            cdb_rd_v      = '0;
            cdb_pc_select = 1'b0;
            cdb_pc_branch = '0;
        end
    end

endmodule : execute

/* hw/fu_alu.sv */
`timescale 1ns/1ps

module fu_alu
    import exec_pkg::*;
(
    input  word_t   rs1_v,
    input  word_t   rs2_v,
    input  word_t   imm,
    input  logic    use_imm,
    input  alu_op_t op,
    output word_t   rd_v
);

    word_t      opnd_b;
    logic [4:0] shamt;

    // immediate form replaces rs2
    assign opnd_b = use_imm ? imm : rs2_v;

    // only the low 5 bits count for shifts
    assign shamt = opnd_b[4:0];

    always_comb begin
        case (op)
            ADD: begin
                rd_v = rs1_v + opnd_b;
            end
            SUB: begin
                rd_v = rs1_v - opnd_b;
            end
            SLL: begin
                rd_v = rs1_v << shamt;
            end
            SLT: begin
                rd_v = {31'b0, $signed(rs1_v) < $signed(opnd_b)};
            end
            SLTU: begin
                rd_v = {31'b0, rs1_v < opnd_b};
            end
            XOR: begin
                rd_v = rs1_v ^ opnd_b;
            end
            SRL: begin
                rd_v = rs1_v >> shamt;
            end
            SRA: begin
                rd_v = $signed(rs1_v) >>> shamt;
            end
            OR: begin
                rd_v = rs1_v | opnd_b;
            end
            AND: begin
                rd_v = rs1_v & opnd_b;
            end
            default: begin
                rd_v = '0;
            end
        endcase
    end

endmodule : fu_alu

/* hw/fu_branch.sv */
`timescale 1ns/1ps

module fu_branch
    import exec_pkg::*;
(
    input  word_t  rs1_v,
    input  word_t  rs2_v,
    input  word_t  imm,
    input  word_t  pc,
    input  br_op_t op,
    output word_t  rd_v,
    output logic   pc_select,
    output word_t  pc_branch
);

    logic  cond_true;
    logic  is_jump;
    word_t target_sum;

    // condition for the six compare forms
    always_comb begin
        case (op)
            BEQ: begin
                cond_true = (rs1_v == rs2_v);
            end
            BNE: begin
                cond_true = (rs1_v != rs2_v);
            end
            BLT: begin
                cond_true = ($signed(rs1_v) < $signed(rs2_v));
            end
            BGE: begin
                cond_true = ($signed(rs1_v) >= $signed(rs2_v));
            end
            BLTU: begin
                cond_true = (rs1_v < rs2_v);
            end
            BGEU: begin
                cond_true = (rs1_v >= rs2_v);
            end
            default: begin
                cond_true = 1'b0;
            end
        endcase
    end

    assign is_jump = (op == JAL) || (op == JALR);

    // jalr is register relative, everything else pc relative
    assign target_sum = ((op == JALR) ? rs1_v : pc) + imm;
    assign pc_branch  = (op == JALR) ? {target_sum[31:1], 1'b0} : target_sum;

    assign pc_select = cond_true || is_jump;

    // link value only for jumps
    assign rd_v = is_jump ? pc + 32'd4 : '0;

endmodule : fu_branch

/* hw/fu_mult.sv */
`timescale 1ns/1ps

module fu_mult
    import exec_pkg::*;
#(
    parameter int PHYS_REG_BITS = 6
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     in_valid,
    input  word_t                    rs1_v,
    input  word_t                    rs2_v,
    input  mul_op_t                  op,
    input  rob_idx_t                 rob_idx,
    input  logic [PHYS_REG_BITS-1:0] pd,
    input  arch_reg_t                rd,
    output logic                     out_valid,
    output word_t                    out_rd_v,
    output rob_idx_t                 out_rob_idx,
    output logic [PHYS_REG_BITS-1:0] out_pd,
    output arch_reg_t                out_rd
);

    logic [MUL_STAGES-1:0]    vld;
    rob_idx_t                 rob_q [MUL_STAGES];
    logic [PHYS_REG_BITS-1:0] pd_q  [MUL_STAGES];
    arch_reg_t                rd_q  [MUL_STAGES];
    mul_op_t                  op_q  [MUL_STAGES-1];

    logic                     a_signed;
    logic                     b_signed;
    logic signed [32:0]       s1_a;
    logic signed [32:0]       s1_b;
    logic signed [50:0]       s2_pp_lo;
    logic signed [48:0]       s2_pp_hi;
    logic signed [65:0]       s3_prod;
    word_t                    s4_res;

    // 33rd bit: sign for signed operands, zero for unsigned ones
    assign a_signed = (op == MULH) || (op == MULHSU);
    assign b_signed = (op == MULH);

    // valid bits and tags move one stage per clock
    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
            for (int i = 0; i < MUL_STAGES; i++) begin
                rob_q[i] <= '0;
                pd_q[i]  <= '0;
                rd_q[i]  <= '0;
            end
        end else begin
            vld      <= flush ? '0 : {vld[MUL_STAGES-2:0], in_valid};
            rob_q[0] <= rob_idx;
            pd_q[0]  <= pd;
            rd_q[0]  <= rd;
            for (int i = 1; i < MUL_STAGES; i++) begin
                rob_q[i] <= rob_q[i-1];
                pd_q[i]  <= pd_q[i-1];
                rd_q[i]  <= rd_q[i-1];
            end
        end
    end

    // datapath: extend, two partial products, sum, pick half
    always_ff @(posedge clk) begin
        op_q[0] <= op;
        for (int i = 1; i < MUL_STAGES - 1; i++) begin
            op_q[i] <= op_q[i-1];
        end
        s1_a     <= {a_signed & rs1_v[31], rs1_v};
        s1_b     <= {b_signed & rs2_v[31], rs2_v};
        // low 17 bits of b are always positive
        s2_pp_lo <= s1_a * $signed({1'b0, s1_b[16:0]});
        s2_pp_hi <= s1_a * $signed(s1_b[32:17]);
        s3_prod  <= s2_pp_lo + (s2_pp_hi <<< 17);
        s4_res   <= (op_q[MUL_STAGES-2] == MUL) ? s3_prod[31:0] : s3_prod[63:32];
    end

    assign out_valid   = vld[MUL_STAGES-1];
    assign out_rd_v    = s4_res;
    assign out_rob_idx = rob_q[MUL_STAGES-1];
    assign out_pd      = pd_q[MUL_STAGES-1];
    assign out_rd      = rd_q[MUL_STAGES-1];

endmodule : fu_mult

/* hw/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage
    import exec_pkg::*;
#(
    parameter int PHYS_REG_BITS = 6
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     start_alu, start_mul, start_br,
    input  word_t                    rs1_v, rs2_v, imm, pc,
    input  logic                     use_imm,
    input  alu_op_t                  alu_op,
    input  mul_op_t                  mul_op,
    input  br_op_t                   br_op,
    input  rob_idx_t                 rob_idx,
    input  logic [PHYS_REG_BITS-1:0] pd,
    input  arch_reg_t                rd,
    output logic                     alu_valid, mul_valid, br_valid,
    output word_t                    alu_rs1_v, alu_rs2_v, alu_imm,
    output logic                     alu_use_imm,
    output alu_op_t                  alu_op_q,
    output word_t                    mul_rs1_v, mul_rs2_v,
    output mul_op_t                  mul_op_q,
    output word_t                    br_rs1_v, br_rs2_v, br_imm, br_pc,
    output br_op_t                   br_op_q,
    output rob_idx_t                 alu_rob_idx, mul_rob_idx, br_rob_idx,
    output logic [PHYS_REG_BITS-1:0] alu_pd, mul_pd, br_pd,
    output arch_reg_t                alu_rd, mul_rd, br_rd
);

    // valids live for exactly one cycle; a start seen with flush is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
            mul_valid <= 1'b0;
            br_valid  <= 1'b0;
        end else begin
            alu_valid <= start_alu && !flush;
            mul_valid <= start_mul && !flush;
            br_valid  <= start_br && !flush;
        end
    end

    // rename tags per unit
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_rob_idx <= '0;
            alu_pd      <= '0;
            alu_rd      <= '0;
            mul_rob_idx <= '0;
            mul_pd      <= '0;
            mul_rd      <= '0;
            br_rob_idx  <= '0;
            br_pd       <= '0;
            br_rd       <= '0;
        end else begin
            if (start_alu) begin
                alu_rob_idx <= rob_idx;
                alu_pd      <= pd;
                alu_rd      <= rd;
            end
            if (start_mul) begin
                mul_rob_idx <= rob_idx;
                mul_pd      <= pd;
                mul_rd      <= rd;
            end
            if (start_br) begin
                br_rob_idx <= rob_idx;
                br_pd      <= pd;
                br_rd      <= rd;
            end
        end
    end

    // operands and op, loaded only on a start
    always_ff @(posedge clk) begin
        if (start_alu) begin
            alu_rs1_v   <= rs1_v;
            alu_rs2_v   <= rs2_v;
            alu_imm     <= imm;
            alu_use_imm <= use_imm;
            alu_op_q    <= alu_op;
        end
        if (start_mul) begin
            mul_rs1_v <= rs1_v;
            mul_rs2_v <= rs2_v;
            mul_op_q  <= mul_op;
        end
        if (start_br) begin
            br_rs1_v <= rs1_v;
            br_rs2_v <= rs2_v;
            br_imm   <= imm;
            br_pc    <= pc;
            br_op_q  <= br_op;
        end
    end

endmodule : issue_stage

/* src.f */
hw/exec_pkg.sv
hw/fu_alu.sv
hw/fu_mult.sv
hw/fu_branch.sv
hw/issue_stage.sv
hw/execute.sv
hw/exec_top.sv
tb/exec_assertions.sv
tb/tb_exec.sv

/* tb/exec_assertions.sv */
`timescale 1ns/1ps

module exec_assertions (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic start_alu,
    input logic start_mul,
    input logic start_br,
    input logic busy_alu,
    input logic busy_br,
    input logic cdb_valid
);

    // assertion failures seen so far
    int fail_count = 0;

    // the issuer starts at most one unit per cycle
    one_start: assert property (@(posedge clk) disable iff (rst)
        $onehot0({start_alu, start_mul, start_br}))
    else begin
        fail_count++;
        $error("more than one start in the same cycle");
    end

    // single-cycle units must not collide with a due mul result
    alu_busy: assert property (@(posedge clk) disable iff (rst)
        start_alu |-> !busy_alu)
    else begin
        fail_count++;
        $error("ALU start while busy_alu is high");
    end

    br_busy: assert property (@(posedge clk) disable iff (rst)
        start_br |-> !busy_br)
    else begin
        fail_count++;
        $error("branch start while busy_br is high");
    end

    // nothing reaches the ROB in a flush cycle
    flush_blank: assert property (@(posedge clk) disable iff (rst)
        flush |-> !cdb_valid)
    else begin
        fail_count++;
        $error("cdb_valid high in a flush cycle");
    end

    reset_quiet: assert property (@(posedge clk) rst |=> !cdb_valid)
    else begin
        fail_count++;
        $error("cdb_valid high right after reset");
    end

endmodule : exec_assertions

bind exec_top exec_assertions u_assert (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .start_alu (start_alu),
    .start_mul (start_mul),
    .start_br  (start_br),
    .busy_alu  (busy_alu),
    .busy_br   (busy_br),
    .cdb_valid (cdb_valid)
);

/* tb/tb_exec.sv */
`timescale 1ns/1ps

module tb_exec
    import exec_pkg::*;
();

    localparam int PD_BITS = 6;

    // instructions issued per test size the watchdog
    localparam int ALU_COUNT       = 20;
    localparam int MUL_COUNT       = 20;
    localparam int BR_COUNT        = 14;
    localparam int BUSY_COUNT      = 2;
    localparam int FLUSH_COUNT     = 4;
    localparam int ISSUE_TOTAL     = ALU_COUNT + MUL_COUNT + BR_COUNT + BUSY_COUNT + FLUSH_COUNT;
    localparam int WATCHDOG_CYCLES = ISSUE_TOTAL * 10 + 100;
    localparam int CDB_WAIT        = 10;

    logic               clk, rst, flush;
    logic               start_alu, start_mul, start_br, use_imm;
    word_t              rs1_v, rs2_v, imm, pc;
    alu_op_t            alu_op;
    mul_op_t            mul_op;
    br_op_t             br_op;
    rob_idx_t           rob_idx;
    logic [PD_BITS-1:0] pd;
    arch_reg_t          rd;
    logic               cdb_valid, cdb_pc_select, busy_alu, busy_br;
    rob_idx_t           cdb_rob_idx;
    logic [PD_BITS-1:0] cdb_pd;
    arch_reg_t          cdb_rd;
    word_t              cdb_rd_v, cdb_pc_branch;

    integer             seed = 32'h97655303;
    int                 error_count = 0;
    int                 check_count = 0;
    int                 assert_fails;
    rob_idx_t           tag_rob;
    logic [PD_BITS-1:0] tag_pd;
    arch_reg_t          tag_rd;

    exec_top #(
        .PHYS_REG_BITS (PD_BITS)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    // signed compare by flipping both sign bits
    function automatic logic less_signed(input word_t a, input word_t b);
        return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 32'd1;
            SLL:     return a << sh;
            SLT:     return {31'd0, less_signed(a, b)};
            SLTU:    return {31'd0, a < b};
            XOR:     return a ^ b;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            OR:      return a | b;
            AND:     return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // 64-bit product of the extended operands modulo 2^64
    function automatic word_t mul_ref(input mul_op_t op, input word_t a, input word_t b);
        logic [63:0] sa, sb, ua, ub, prod;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        case (op)
            MULH:    prod = sa * sb;
            MULHSU:  prod = sa * ub;
            default: prod = ua * ub;
        endcase
        return (op == MUL) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic void branch_ref(input br_op_t op, input word_t a, input word_t b,
                                       input word_t offs, input word_t pc_in,
                                       output logic taken, output word_t target,
                                       output word_t link);
        case (op)
            BEQ:     taken = (a == b);
            BNE:     taken = (a != b);
            BLT:     taken = less_signed(a, b);
            BGE:     taken = !less_signed(a, b);
            BLTU:    taken = (a < b);
            BGEU:    taken = !(a < b);
            default: taken = 1'b1;
        endcase
        if (op == JALR) begin
            target = (a + offs) & 32'hffff_fffe;
        end else begin
            target = pc_in + offs;
        end
        link = (op == JAL || op == JALR) ? pc_in + 32'd4 : 32'd0;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected,
                     $time);
        end
    endtask

    task automatic compare_cdb(input rob_idx_t exp_rob, input logic [PD_BITS-1:0] exp_pd,
                               input arch_reg_t exp_rd, input word_t exp_rd_v,
                               input logic exp_sel, input word_t exp_target);
        check_value("cdb_valid", cdb_valid, 1);
        check_value("cdb_rob_idx", cdb_rob_idx, exp_rob);
        check_value("cdb_pd", cdb_pd, exp_pd);
        check_value("cdb_rd", cdb_rd, exp_rd);
        check_value("cdb_rd_v", cdb_rd_v, exp_rd_v);
        check_value("cdb_pc_select", cdb_pc_select, exp_sel);
        check_value("cdb_pc_branch", cdb_pc_branch, exp_target);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs();
        start_alu = 1'b0;
        start_mul = 1'b0;
        start_br  = 1'b0;
        flush     = 1'b0;
        use_imm   = 1'b0;
        rs1_v     = '0;
        rs2_v     = '0;
        imm       = '0;
        pc        = '0;
        alu_op    = ADD;
        mul_op    = MUL;
        br_op     = BEQ;
        rob_idx   = '0;
        pd        = '0;
        rd        = '0;
    endtask

    task automatic pick_tags();
        word_t r;
        r       = rand_word();
        tag_rob = r[4:0];
        tag_pd  = r[13:8];
        tag_rd  = r[20:16];
    endtask

    task automatic release_starts();
        start_alu = 1'b0;
        start_mul = 1'b0;
        start_br  = 1'b0;
    endtask

    task automatic issue_alu(input alu_op_t op, input word_t a, input word_t b,
                             input word_t offs, input logic imm_form);
        release_starts();
        start_alu = 1'b1;
        alu_op    = op;
        rs1_v     = a;
        rs2_v     = b;
        imm       = offs;
        use_imm   = imm_form;
        rob_idx   = tag_rob;
        pd        = tag_pd;
        rd        = tag_rd;
    endtask

    task automatic issue_mul(input mul_op_t op, input word_t a, input word_t b);
        release_starts();
        start_mul = 1'b1;
        mul_op    = op;
        rs1_v     = a;
        rs2_v     = b;
        rob_idx   = tag_rob;
        pd        = tag_pd;
        rd        = tag_rd;
    endtask

    task automatic issue_branch(input br_op_t op, input word_t a, input word_t b,
                                input word_t offs, input word_t pc_v);
        release_starts();
        start_br = 1'b1;
        br_op    = op;
        rs1_v    = a;
        rs2_v    = b;
        imm      = offs;
        pc       = pc_v;
        rob_idx  = tag_rob;
        pd       = tag_pd;
        rd       = tag_rd;
    endtask

    // counts falling edges until cdb_valid shows up
    task automatic wait_for_cdb(output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < CDB_WAIT) begin
            @(negedge clk);
            cycles++;
            seen = cdb_valid;
        end
        if (!seen) begin
            error_count++;
            $display("no result on the CDB within %0d cycles of the start", CDB_WAIT);
        end
    endtask

    task automatic complete_single(input int latency, input word_t exp_rd_v,
                                   input logic exp_sel, input word_t exp_target);
        int cycles;
        bit seen;
        next_cycle();
        release_starts();
        wait_for_cdb(cycles, seen);
        if (seen) begin
            check_value("cdb latency", cycles, latency);
            compare_cdb(tag_rob, tag_pd, tag_rd, exp_rd_v, exp_sel, exp_target);
        end
    endtask

    task automatic alu_ops_test();
        word_t   a, b, offs;
        alu_op_t op;
        for (int form = 0; form < 2; form++) begin
            for (int i = 0; i < 10; i++) begin
                op   = alu_op_t'(i);
                a    = rand_word();
                b    = rand_word();
                offs = rand_word();
                offs = {{20{offs[11]}}, offs[11:0]};
                pick_tags();
                next_cycle();
                issue_alu(op, a, b, offs, form == 1);
                complete_single(1, alu_ref(op, a, (form == 1) ? offs : b), 1'b0, 32'd0);
            end
        end
    endtask

    task automatic mul_corner_test();
        word_t   a_list [4];
        word_t   b_list [4];
        mul_op_t op;
        a_list = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'd0};
        b_list = '{32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'd0};
        a_list[3] = rand_word();
        b_list[3] = rand_word();
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                op = mul_op_t'(i);
                pick_tags();
                next_cycle();
                issue_mul(op, a_list[j], b_list[j]);
                complete_single(1 + MUL_STAGES, mul_ref(op, a_list[j], b_list[j]), 1'b0, 32'd0);
            end
        end
    endtask

    // four muls on back-to-back cycles return in order
    task automatic mul_burst_test();
        word_t              a_q [4];
        word_t              b_q [4];
        rob_idx_t           rob_q [4];
        logic [PD_BITS-1:0] pd_q [4];
        arch_reg_t          rd_q [4];
        int                 cycles;
        bit                 seen;
        for (int i = 0; i < 4; i++) begin
            a_q[i] = rand_word();
            b_q[i] = rand_word();
            pick_tags();
            rob_q[i] = tag_rob;
            pd_q[i]  = tag_pd;
            rd_q[i]  = tag_rd;
            next_cycle();
            issue_mul(mul_op_t'(i), a_q[i], b_q[i]);
        end
        next_cycle();
        release_starts();
        wait_for_cdb(cycles, seen);
        if (seen) begin
            // the first mul went in three cycles before the wait began
            check_value("cdb latency", cycles, 1 + MUL_STAGES - 3);
            for (int i = 0; i < 4; i++) begin
                if (i > 0) begin
                    @(negedge clk);
                end
                compare_cdb(rob_q[i], pd_q[i], rd_q[i], mul_ref(mul_op_t'(i), a_q[i], b_q[i]),
                            1'b0, 32'd0);
            end
            @(negedge clk);
            check_value("cdb_valid", cdb_valid, 0);
        end
    endtask

    task automatic branch_test();
        word_t  a, b, offs, pc_v, target, link;
        logic   taken;
        br_op_t op;
        for (int i = 0; i < BR_COUNT; i++) begin
            if (i < 12) begin
                op = br_op_t'(i % 6);
            end else begin
                op = (i == 12) ? JAL : JALR;
            end
            // equal operands first, then negative rs1 against positive rs2
            a = rand_word();
            b = (i < 6) ? a : (a & 32'h7fff_ffff);
            if (i >= 6) begin
                a = a | 32'h8000_0000;
            end
            offs = rand_word();
            offs = {{19{offs[12]}}, offs[12:1], 1'b0};
            pc_v = rand_word() & 32'hffff_fffc;
            // odd jalr sum so that bit 0 has to be cleared
            if (op == JALR) begin
                a[0] = ~offs[0];
            end
            branch_ref(op, a, b, offs, pc_v, taken, target, link);
            pick_tags();
            next_cycle();
            issue_branch(op, a, b, offs, pc_v);
            complete_single(1, link, taken, target);
        end
    endtask

    task automatic busy_protocol_test();
        word_t              a, b, c, d;
        rob_idx_t           mul_rob;
        logic [PD_BITS-1:0] mul_pd;
        arch_reg_t          mul_rd;
        int                 waited;
        a = rand_word();
        b = rand_word();
        c = rand_word();
        d = rand_word();
        pick_tags();
        mul_rob = tag_rob;
        mul_pd  = tag_pd;
        mul_rd  = tag_rd;
        next_cycle();
        issue_mul(MULHU, a, b);
        next_cycle();
        release_starts();
        // busy rises three cycles after the mul is latched
        for (int k = 1; k <= 3; k++) begin
            next_cycle();
            check_value("busy_alu", busy_alu, k == 3);
            check_value("busy_br", busy_br, k == 3);
        end
        waited = 0;
        while (busy_alu && waited < CDB_WAIT) begin
            next_cycle();
            waited++;
        end
        if (busy_alu) begin
            error_count++;
            $display("busy_alu never dropped after the mul was issued");
        end
        pick_tags();
        issue_alu(XOR, c, d, 32'd0, 1'b0);
        @(negedge clk);
        compare_cdb(mul_rob, mul_pd, mul_rd, mul_ref(MULHU, a, b), 1'b0, 32'd0);
        next_cycle();
        release_starts();
        @(negedge clk);
        compare_cdb(tag_rob, tag_pd, tag_rd, alu_ref(XOR, c, d), 1'b0, 32'd0);
    endtask

    task automatic flush_test();
        word_t a, b;
        bit    seen;
        a = rand_word();
        b = rand_word();
        pick_tags();
        next_cycle();
        issue_mul(MUL, a, b);
        pick_tags();
        next_cycle();
        issue_mul(MULH, b, a);
        pick_tags();
        next_cycle();
        issue_alu(ADD, a, b, 32'd0, 1'b0);
        next_cycle();
        release_starts();
        flush = 1'b1;
        // ALU result is due in this cycle and must be blanked
        @(negedge clk);
        check_value("cdb_valid", cdb_valid, 0);
        next_cycle();
        flush = 1'b0;
        seen  = 1'b0;
        for (int k = 0; k < 2 * MUL_STAGES; k++) begin
            @(negedge clk);
            seen = seen | cdb_valid;
        end
        if (seen) begin
            error_count++;
            $display("a flushed instruction still reached the CDB");
        end
        pick_tags();
        next_cycle();
        issue_alu(SUB, a, b, 32'd0, 1'b0);
        complete_single(1, alu_ref(SUB, a, b), 1'b0, 32'd0);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clear_inputs();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("cdb_valid", cdb_valid, 0);
        check_value("busy_alu", busy_alu, 0);
        check_value("busy_br", busy_br, 0);
        alu_ops_test();
        mul_corner_test();
        mul_burst_test();
        branch_test();
        busy_protocol_test();
        flush_test();
        assert_fails = dut.u_assert.fail_count;
        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_exec
